// ==== verilog/vram_pkg.sv ====
// memory-side types for the video RAM block, imported by the RTL and the testbench
package vram_pkg;

   // ------------------------------------------------------------------
   // word and address
   // ------------------------------------------------------------------

   localparam int WORD_BITS = 32;   // pixels per word
   localparam int ADDR_BITS = 15;   // full word address as seen by the cpu

   typedef logic [WORD_BITS-1:0] vram_word_t;

   // only the low bits reach the array
   typedef logic [ADDR_BITS-1:0] vram_addr_t;

   // ------------------------------------------------------------------
   // cpu command
   // ------------------------------------------------------------------

   // one access, latched by the cpu port on an accepted strobe
   typedef struct packed {
      vram_addr_t addr;
      vram_word_t wdata;   // don't care on reads
      logic       write;
   } cpu_req_t;

endpackage

// ==== verilog/vga_pkg.sv ====
// display-side types for the scanout path, imported by the fetcher and the testbench
package vga_pkg;

   // both syncs are active low
   localparam logic SYNC_IDLE = 1'b1;

   // ------------------------------------------------------------------
   // pixel output
   // ------------------------------------------------------------------

   typedef struct packed {
      logic pix;      // 1 = lit, forced low outside active video
      logic active;
      logic hsync;
      logic vsync;
   } vga_pix_t;

   // ------------------------------------------------------------------
   // raster position
   // ------------------------------------------------------------------

   typedef logic [11:0] scan_cnt_t;

   typedef struct packed {
      scan_cnt_t h;   // pixel within line, blank first
      scan_cnt_t v;   // line within frame, active lines first
   } scan_pos_t;

endpackage

// ==== verilog/cpu_vram_port.sv ====
// cpu side of the video RAM: holds one request for the arbiter and returns done with data
`timescale 1ns/1ps

module cpu_vram_port (
   input  logic                 clk,
   input  logic                 arst_n,
   input  logic                 cpu_req,
   input  vram_pkg::cpu_req_t   cpu_cmd,
   input  logic                 grant_cpu,
   input  vram_pkg::vram_word_t rsp_data,
   output logic                 cpu_ready,
   output logic                 cpu_done,
   output logic                 pend_valid,
   output vram_pkg::cpu_req_t   pend_cmd,
   output vram_pkg::vram_word_t cpu_rdata
);

   logic accept;
   logic rsp_wait;   // granted last cycle, array data due now

   // busy from the accepted strobe until done goes out
   assign cpu_ready = ~(pend_valid | rsp_wait);
   assign accept    = cpu_req & cpu_ready;

   // ------------------------------------------------------------------
   // request state
   // ------------------------------------------------------------------

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         pend_valid <= 1'b0;
         rsp_wait   <= 1'b0;
         cpu_done   <= 1'b0;
      end else begin
         if (accept)
            pend_valid <= 1'b1;
         else if (grant_cpu)
            pend_valid <= 1'b0;

         rsp_wait <= pend_valid & grant_cpu;
         cpu_done <= rsp_wait;
      end
   end

   // ------------------------------------------------------------------
   // command and read data
   // ------------------------------------------------------------------

   // command stays put after the grant, write flag still needed below
   always_ff @(posedge clk) begin
      if (accept)
         pend_cmd <= cpu_cmd;
   end

   always_ff @(posedge clk) begin
      if (rsp_wait && !pend_cmd.write)
         cpu_rdata <= rsp_data;   // valid with cpu_done
   end

endmodule

// ==== verilog/vga_fetch.sv ====
// VGA scanout for vram_top: raster counters, syncs, word prefetch and the pixel shifter
`timescale 1ns/1ps

module vga_fetch #(
   parameter int H_WORDS = 2,
   parameter int H_BLANK = 16,
   parameter int H_SYNC  = 4,
   parameter int V_LINES = 4,
   parameter int V_BLANK = 2
) (
   input  logic                 clk,
   input  logic                 arst_n,
   input  logic                 vga_ready,
   input  vram_pkg::vram_word_t vga_data,
   output logic                 vga_req,
   output vram_pkg::vram_addr_t vga_addr,
   output vga_pkg::vga_pix_t    vga_pix
);

   import vram_pkg::*;
   import vga_pkg::*;

   localparam int H_TOTAL  = H_WORDS * WORD_BITS + H_BLANK;
   localparam int V_TOTAL  = V_LINES + V_BLANK;
   localparam int HS_START = 2;   // hsync offset into the blank
   localparam int PREFETCH = 4;   // lead of the first word of a line
   localparam int CNT_W    = $bits(scan_cnt_t);
   localparam int WSH      = $clog2(WORD_BITS);
   localparam int WIDX_W   = CNT_W - WSH;

   scan_pos_t               pos;
   scan_cnt_t               col;
   logic [WIDX_W-1:0]       word_idx;
   logic                    line_act;
   logic                    in_active;
   logic                    word_start;
   logic                    hs_on;
   logic                    vs_on;
   logic                    pix_bit;
   vram_word_t              wbuf;
   vram_word_t              shreg;

   // ------------------------------------------------------------------
   // raster
   // ------------------------------------------------------------------

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         pos <= '0;
      end else if (pos.h == scan_cnt_t'(H_TOTAL - 1)) begin
         pos.h <= '0;
         if (pos.v == scan_cnt_t'(V_TOTAL - 1))
            pos.v <= '0;
         else
            pos.v <= pos.v + 1'b1;
      end else begin
         pos.h <= pos.h + 1'b1;
      end
   end

   assign col        = pos.h - scan_cnt_t'(H_BLANK);   // meaningful only when active
   assign word_idx   = col[CNT_W-1:WSH];
   assign line_act   = pos.v < scan_cnt_t'(V_LINES);
   assign in_active  = line_act && pos.h >= scan_cnt_t'(H_BLANK);
   assign word_start = in_active && col[WSH-1:0] == '0;
   assign hs_on      = pos.h >= scan_cnt_t'(HS_START) &&
                       pos.h < scan_cnt_t'(HS_START + H_SYNC);
   assign vs_on      = pos.v == scan_cnt_t'(V_LINES);   // first blank line

   // ------------------------------------------------------------------
   // word fetch
   // ------------------------------------------------------------------

   assign vga_req = line_act &&
                    (pos.h == scan_cnt_t'(H_BLANK - PREFETCH) ||
                     (word_start && word_idx < WIDX_W'(H_WORDS - 1)));

   // sequential from base 0, i.e. line * H_WORDS + word
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n)
         vga_addr <= '0;
      else if (!line_act)
         vga_addr <= '0;
      else if (vga_req)
         vga_addr <= vga_addr + 1'b1;
   end

   // buffer is consumed on the first pixel of each word
   always_ff @(posedge clk) begin
      if (vga_ready)
         wbuf <= vga_data;
      if (word_start)
         shreg <= wbuf >> 1;
      else if (in_active)
         shreg <= shreg >> 1;   // lsb first
   end

   assign pix_bit = word_start ? wbuf[0] : shreg[0];

   // ------------------------------------------------------------------
   // output register
   // ------------------------------------------------------------------

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         vga_pix <= '{pix: 1'b0, active: 1'b0, hsync: SYNC_IDLE, vsync: SYNC_IDLE};
      end else begin
         vga_pix.pix    <= in_active & pix_bit;
         vga_pix.active <= in_active;
         vga_pix.hsync  <= hs_on ? ~SYNC_IDLE : SYNC_IDLE;
         vga_pix.vsync  <= vs_on ? ~SYNC_IDLE : SYNC_IDLE;
      end
   end

endmodule

// ==== verilog/vram_arbiter.sv ====
// single-ported video RAM with fixed VGA-first arbitration, used inside vram_top
`timescale 1ns/1ps

module vram_arbiter #(
   parameter int VRAM_ADDR_W = 6
) (
   input  logic                 clk,
   input  logic                 arst_n,
   input  logic                 vga_req,
   input  vram_pkg::vram_addr_t vga_addr,
   input  logic                 pend_valid,
   input  vram_pkg::cpu_req_t   pend_cmd,
   output logic                 vga_ready,
   output vram_pkg::vram_word_t vga_data,
   output logic                 grant_cpu,
   output vram_pkg::vram_word_t rsp_data
);

   import vram_pkg::*;

   localparam int DEPTH = 1 << VRAM_ADDR_W;

   vram_word_t             mem [DEPTH];
   logic [VRAM_ADDR_W-1:0] sel_addr;
   logic                   rd_en;
   vram_word_t             rd_q;
   logic                   vga_own;   // previous cycle served the fetcher
   logic                   cpu_own;   // previous cycle served the cpu

   // ------------------------------------------------------------------
   // selection
   // ------------------------------------------------------------------

   // scanout can't wait, the cpu slips a cycle instead
   assign grant_cpu = pend_valid & ~vga_req;

   assign sel_addr = vga_req ? vga_addr[VRAM_ADDR_W-1:0]
                             : pend_cmd.addr[VRAM_ADDR_W-1:0];

   assign rd_en = vga_req | (grant_cpu & ~pend_cmd.write);

   // ------------------------------------------------------------------
   // array
   // ------------------------------------------------------------------

   always_ff @(posedge clk) begin
      if (grant_cpu && pend_cmd.write)
         mem[sel_addr] <= pend_cmd.wdata;
      if (rd_en)
         rd_q <= mem[sel_addr];
   end

   // ------------------------------------------------------------------
   // response steering
   // ------------------------------------------------------------------

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         vga_own <= 1'b0;
         cpu_own <= 1'b0;
      end else begin
         vga_own <= vga_req;
         cpu_own <= grant_cpu;
      end
   end

   assign vga_ready = vga_own;
   assign vga_data  = vga_own ? rd_q : '0;
   assign rsp_data  = cpu_own ? rd_q : '0;   // old word on a write, port drops it

endmodule

// ==== verilog/vram_top.sv ====
// video RAM block top: cpu port, VGA fetcher and arbiter around one word array
`timescale 1ns/1ps

module vram_top #(
   parameter int VRAM_ADDR_W = 6,
   parameter int H_WORDS     = 2,    // 64 active pixels
   parameter int H_BLANK     = 16,
   parameter int H_SYNC      = 4,
   parameter int V_LINES     = 4,
   parameter int V_BLANK     = 2
) (
   input  logic                 clk,
   input  logic                 arst_n,
   input  logic                 cpu_req,
   input  vram_pkg::cpu_req_t   cpu_cmd,
   output logic                 cpu_ready,
   output logic                 cpu_done,
   output vram_pkg::vram_word_t cpu_rdata,
   output vga_pkg::vga_pix_t    vga_pix
);

   import vram_pkg::*;

   // ------------------------------------------------------------------
   // interconnect
   // ------------------------------------------------------------------

   logic       pend_valid;
   cpu_req_t   pend_cmd;
   logic       grant_cpu;
   vram_word_t rsp_data;

   logic       vga_req;
   vram_addr_t vga_addr;
   logic       vga_ready;
   vram_word_t vga_data;

   cpu_vram_port port0 (
      .clk        (clk),
      .arst_n     (arst_n),
      .cpu_req    (cpu_req),
      .cpu_cmd    (cpu_cmd),
      .grant_cpu  (grant_cpu),
      .rsp_data   (rsp_data),
      .cpu_ready  (cpu_ready),
      .cpu_done   (cpu_done),
      .pend_valid (pend_valid),
      .pend_cmd   (pend_cmd),
      .cpu_rdata  (cpu_rdata)
   );

   vga_fetch #(
      .H_WORDS (H_WORDS),
      .H_BLANK (H_BLANK),
      .H_SYNC  (H_SYNC),
      .V_LINES (V_LINES),
      .V_BLANK (V_BLANK)
   ) vga0 (
      .clk       (clk),
      .arst_n    (arst_n),
      .vga_ready (vga_ready),
      .vga_data  (vga_data),
      .vga_req   (vga_req),
      .vga_addr  (vga_addr),
      .vga_pix   (vga_pix)
   );

   vram_arbiter #(
      .VRAM_ADDR_W (VRAM_ADDR_W)
   ) arb0 (
      .clk        (clk),
      .arst_n     (arst_n),
      .vga_req    (vga_req),
      .vga_addr   (vga_addr),
      .pend_valid (pend_valid),
      .pend_cmd   (pend_cmd),
      .vga_ready  (vga_ready),
      .vga_data   (vga_data),
      .grant_cpu  (grant_cpu),
      .rsp_data   (rsp_data)
   );

endmodule

// ==== tb/tb_vram.sv ====
// simulation top that checks vram_top cpu accesses against a word model and its scanout and syncs
`timescale 1ns/1ps

module tb_vram;

   import vram_pkg::*;
   import vga_pkg::*;

   localparam int DEPTH      = 64;   // 1 << VRAM_ADDR_W
   localparam int H_WORDS    = 2;
   localparam int H_BLANK    = 16;
   localparam int H_SYNC     = 4;
   localparam int V_LINES    = 4;
   localparam int V_BLANK    = 2;
   localparam int LINE_PIX   = H_WORDS * 32;
   localparam int H_TOTAL    = LINE_PIX + H_BLANK;
   localparam int FRAME_CYC  = H_TOTAL * (V_LINES + V_BLANK);
   localparam int DISP_WORDS = V_LINES * H_WORDS;

   logic        clk;
   logic        arst_n;
   logic        cpu_req;
   cpu_req_t    cpu_cmd;
   logic        cpu_ready;
   logic        cpu_done;
   vram_word_t  cpu_rdata;
   vga_pix_t    vga_pix;

   logic [31:0] rng;
   vram_word_t  model [DEPTH];
   logic        written [DEPTH];
   logic        frame_busy;

   // sync monitor state
   int cyc       = 0;
   int hs_len    = 0;
   int hs_last   = -1;
   int vs_len    = 0;
   int vs_last   = -1;
   int act_len   = 0;
   int act_lines = 0;

   vram_top dut0 (
      .clk       (clk),
      .arst_n    (arst_n),
      .cpu_req   (cpu_req),
      .cpu_cmd   (cpu_cmd),
      .cpu_ready (cpu_ready),
      .cpu_done  (cpu_done),
      .cpu_rdata (cpu_rdata),
      .vga_pix   (vga_pix)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   task automatic stop_run(input string why);
      $display("%s", why);
      $display("TESTBENCH FAILED");
      $fatal(1);
   endtask

   task automatic value_error(input string msg);
      stop_run($sformatf("Error at %0t: %s", $time, msg));
   endtask

   function automatic logic [31:0] next_rand();
      rng = rng * 32'd1664525 + 32'd1013904223;
      return rng;
   endfunction

   task automatic check_idle();
      assert (cpu_ready && !cpu_done && vga_pix.hsync == SYNC_IDLE &&
              vga_pix.vsync == SYNC_IDLE && !vga_pix.active)
         else value_error("outputs not in their reset state");
   endtask

   // ------------------------------------------------------------------
   // cpu side
   // ------------------------------------------------------------------

   // starts on a falling edge with the port idle and ends one edge after done
   task automatic do_access(input logic wr, input int addr, input vram_word_t wdata,
                            output vram_word_t rdata);
      int          waits;
      logic [31:0] r;
      waits = 0;
      assert (cpu_ready && !cpu_done) else value_error("port not idle before a request");
      cpu_cmd = '{addr: vram_addr_t'(addr), wdata: wdata, write: wr};
      cpu_req = 1'b1;
      do begin
         @(negedge clk);
         waits++;
         cpu_req = 1'b0;
         if (!cpu_done) begin
            assert (!cpu_ready) else value_error("cpu_ready high while a request is pending");
            if (waits > 6)
               stop_run("a cpu request never finished");
            r       = next_rand();
            cpu_req = r[0];   // busy so this strobe must be dropped
            cpu_cmd = '{addr: vram_addr_t'(r[14:8]), wdata: r, write: r[1]};
         end
      end while (!cpu_done);
      assert (waits - 1 >= 2 && waits - 1 <= 4)
         else value_error($sformatf("request took %0d cycles", waits - 1));
      rdata = cpu_rdata;
      @(negedge clk);
      assert (!cpu_done) else value_error("cpu_done longer than one cycle");
   endtask

   // writes stay at or above min_wr and reads only hit written words
   task automatic random_op(input int min_wr);
      logic [31:0] r;
      int          a;
      logic        wr;
      vram_word_t  rd;
      r  = next_rand();
      a  = int'(r[13:8]);
      wr = r[0] | ~written[a];
      if (wr && a < min_wr)
         a = min_wr + a % (DEPTH - min_wr);
      if (wr) begin
         model[a]   = next_rand();
         written[a] = 1'b1;
         do_access(1'b1, a, model[a], rd);
      end else begin
         do_access(1'b0, a, '0, rd);
         assert (rd == model[a])
            else value_error($sformatf("word %0d read %h, expected %h", a, rd, model[a]));
      end
      if (r[3])
         @(negedge clk);   // shifts the phase against the fetches
   endtask

   // ------------------------------------------------------------------
   // scanout
   // ------------------------------------------------------------------

   task automatic check_frame();
      int   idx;
      int   line;
      int   col;
      logic exp;
      idx = 0;
      while (vga_pix.vsync != SYNC_IDLE)
         @(negedge clk);
      while (vga_pix.vsync == SYNC_IDLE)
         @(negedge clk);
      while (idx < DISP_WORDS * 32) begin
         @(negedge clk);
         if (vga_pix.active) begin
            line = idx / LINE_PIX;
            col  = idx % LINE_PIX;
            exp  = 1'(model[line * H_WORDS + col / 32] >> (col % 32));   // lsb first
            assert (vga_pix.pix == exp)
               else value_error($sformatf("line %0d pixel %0d is %b, expected %b",
                                          line, col, vga_pix.pix, exp));
            idx++;
         end
      end
   endtask

   always @(negedge clk) begin
      if (arst_n) begin
         cyc++;
         if (vga_pix.hsync != SYNC_IDLE) begin
            if (hs_len == 0) begin
               if (hs_last >= 0)
                  assert (cyc - hs_last == H_TOTAL)
                     else value_error($sformatf("hsync falls %0d apart", cyc - hs_last));
               hs_last = cyc;
            end
            hs_len++;
         end else if (hs_len != 0) begin
            assert (hs_len == H_SYNC) else value_error($sformatf("hsync low %0d", hs_len));
            hs_len = 0;
         end
         // active first so its last run ends on the vsync fall
         if (vga_pix.active) begin
            act_len++;
         end else if (act_len != 0) begin
            assert (act_len == LINE_PIX) else value_error($sformatf("active run %0d", act_len));
            act_len = 0;
            act_lines++;
         end
         if (vga_pix.vsync != SYNC_IDLE) begin
            if (vs_len == 0) begin
               assert (act_lines == V_LINES)
                  else value_error($sformatf("%0d active lines in a frame", act_lines));
               if (vs_last >= 0)
                  assert (cyc - vs_last == FRAME_CYC)
                     else value_error($sformatf("vsync falls %0d apart", cyc - vs_last));
               vs_last   = cyc;
               act_lines = 0;
            end
            vs_len++;
         end else if (vs_len != 0) begin
            assert (vs_len == H_TOTAL) else value_error($sformatf("vsync low %0d", vs_len));
            vs_len = 0;
         end
      end
   end

   accept_drops_ready: assert property (@(posedge clk) disable iff (!arst_n)
      cpu_req && cpu_ready |=> !cpu_ready)
      else value_error("cpu_ready still high after an accepted strobe");

   done_after_busy: assert property (@(posedge clk) disable iff (!arst_n)
      cpu_done |-> !$past(cpu_ready))
      else value_error("cpu_done without a pending request");

   done_one_cycle: assert property (@(posedge clk) disable iff (!arst_n)
      cpu_done |=> !cpu_done)
      else value_error("cpu_done held for more than one cycle");

   syncs_idle_active: assert property (@(posedge clk) disable iff (!arst_n)
      vga_pix.active |-> vga_pix.hsync == SYNC_IDLE && vga_pix.vsync == SYNC_IDLE)
      else value_error("sync pulse inside active video");

   blank_is_dark: assert property (@(posedge clk) disable iff (!arst_n)
      !vga_pix.active |-> !vga_pix.pix)
      else value_error("lit pixel outside active video");

   // ------------------------------------------------------------------
   // test sequence
   // ------------------------------------------------------------------

   initial begin
      vram_word_t rd;
      vram_word_t wd;
      rng        = 32'h48bf;
      arst_n     = 1'b0;
      cpu_req    = 1'b0;
      cpu_cmd    = '0;
      frame_busy = 1'b0;
      for (int i = 0; i < DEPTH; i++)
         written[i] = 1'b0;

      repeat (3) begin
         @(negedge clk);
         check_idle();
      end
      arst_n = 1'b1;
      @(negedge clk);
      check_idle();

      wd = next_rand();
      do_access(1'b1, 5, wd, rd);
      model[5]   = wd;
      written[5] = 1'b1;
      do_access(1'b0, 5, '0, rd);
      assert (rd == wd) else value_error($sformatf("read back %h, expected %h", rd, wd));

      repeat (200)
         random_op(0);

      // display area then one quiet frame
      for (int w = 0; w < DISP_WORDS; w++) begin
         model[w]   = next_rand();
         written[w] = 1'b1;
         do_access(1'b1, w, model[w], rd);
      end
      check_frame();

      // same frame again with cpu traffic alongside
      frame_busy = 1'b1;
      fork
         begin
            check_frame();
            frame_busy = 1'b0;
         end
         while (frame_busy)
            random_op(DISP_WORDS);
      join

      $display("TESTBENCH PASSED");
      $finish;
   end

   initial begin
      repeat (4 * FRAME_CYC + 2000)
         @(posedge clk);
      stop_run("simulation hung, watchdog expired before the tests finished");
   end

endmodule

// ==== build.f ====
verilog/vram_pkg.sv
verilog/vga_pkg.sv
verilog/cpu_vram_port.sv
verilog/vga_fetch.sv
verilog/vram_arbiter.sv
verilog/vram_top.sv
tb/tb_vram.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile the video RAM testbench with Verilator and run it
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
   --top-module tb_vram \
   --Mdir obj_dir -o sim_vram \
   -f build.f
status=$?
if [ "$status" -ne 0 ]; then
   echo "verilator compile failed"
   exit "$status"
fi

./obj_dir/sim_vram
status=$?
if [ "$status" -ne 0 ]; then
   echo "simulation exited with status $status"
   exit "$status"
fi

exit 0
